// ==== all.f ====
+incdir+include
hw/pipe_ctrl_pkg.sv
hw/hazard_control.sv
hw/pc_unit.sv
hw/branch_predictor.sv
hw/cp0_regs.sv
hw/pipe_ctrl_top.sv
tb/pipe_ctrl_tb.sv

// ==== hw/branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor #(
    parameter int BTB_INDEX_BITS = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  pipe_ctrl_pkg::addr_t       pc,
    input  pipe_ctrl_pkg::bpu_update_t update,
    output pipe_ctrl_pkg::addr_t       predicted_pc
);

    import pipe_ctrl_pkg::*;

    localparam int DEPTH     = 1 << BTB_INDEX_BITS;
    localparam int TAG_LSB   = BTB_INDEX_BITS + 2;
    localparam int TAG_BITS  = 32 - TAG_LSB;

    typedef logic [BTB_INDEX_BITS-1:0] btb_index_t;
    typedef logic [TAG_BITS-1:0]       btb_tag_t;

    logic [DEPTH-1:0] valid_q;
    btb_tag_t         tag_mem    [DEPTH];
    addr_t            target_mem [DEPTH];

    btb_index_t rd_index;
    btb_tag_t   rd_tag;
    btb_index_t wr_index;
    btb_tag_t   wr_tag;
    logic       hit;

    // Word aligned fetch, so index starts at bit 2
    assign rd_index = pc[TAG_LSB-1:2];
    assign rd_tag   = pc[31:TAG_LSB];
    assign wr_index = update.pc[TAG_LSB-1:2];
    assign wr_tag   = update.pc[31:TAG_LSB];

    ////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////

    assign hit = valid_q[rd_index] && (tag_mem[rd_index] == rd_tag);

    always_comb begin
        if (hit) begin
            predicted_pc = target_mem[rd_index];
        end else begin
            predicted_pc = pc + addr_t'(4);
        end
    end

    ////////////////////////////////////////////////////////////
    // Retrain on mispredict
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (update.en) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    // Tag and target of the retrained entry
    always_ff @(posedge clk) begin
        if (update.en) begin
            tag_mem[wr_index]    <= wr_tag;
            target_mem[wr_index] <= update.target;
        end
    end

endmodule

// ==== hw/cp0_regs.sv ====
`timescale 1ns/1ps

module cp0_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  pipe_ctrl_pkg::cp0_req_t req,
    input  logic                    ext_intr,
    output logic                    cp0_intr,
    output pipe_ctrl_pkg::addr_t    epc,
    output pipe_ctrl_pkg::exc_code_t cause
);

    import pipe_ctrl_pkg::*;

    addr_t     epc_q;
    exc_code_t cause_q;
    logic      exl_q;

    ////////////////////////////////////////////////////////////
    // Exception level
    ////////////////////////////////////////////////////////////

    // Entry takes precedence if both arrive together
    always_ff @(posedge clk) begin
        if (rst) begin
            exl_q <= 1'b0;
        end else if (req.w_en) begin
            exl_q <= 1'b1;
        end else if (req.eret) begin
            exl_q <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // EPC and cause
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            epc_q   <= '0;
            cause_q <= '0;
        end else if (req.w_en) begin
            epc_q   <= req.epc;
            cause_q <= req.exc_code;
        end
    end

    // Masked while in the handler so a held line is taken once
    assign cp0_intr = ext_intr && !exl_q;

    assign epc   = epc_q;
    assign cause = cause_q;

endmodule

// ==== hw/hazard_control.sv ====
`timescale 1ns/1ps

module hazard_control (
    input  logic                      id_jr,
    input  logic                      id_jump,
    input  logic                      mem_stall,
    input  logic                      idex_mem_read,
    input  logic                      exmem_eret,
    input  logic                      exmem_syscall,
    input  logic                      cp0_intr,
    input  pipe_ctrl_pkg::reg_addr_t  ifid_rs_addr,
    input  pipe_ctrl_pkg::reg_addr_t  real_rt_addr,
    input  pipe_ctrl_pkg::reg_addr_t  idex_rd_addr,
    input  pipe_ctrl_pkg::addr_t      predicted_idex_pc,
    input  pipe_ctrl_pkg::addr_t      target_exmem_pc,
    input  pipe_ctrl_pkg::addr_t      exmem_pc,
    output pipe_ctrl_pkg::pc_src_e    pc_src,
    output pipe_ctrl_pkg::stall_ctrl_t stall,
    output pipe_ctrl_pkg::flush_ctrl_t flush,
    output pipe_ctrl_pkg::cp0_req_t   cp0_req,
    output pipe_ctrl_pkg::bpu_update_t bpu_update
);

    import pipe_ctrl_pkg::*;

    logic load_use_hazard;
    logic branch_hazard;

    // Load in EX feeding a source of the instruction in ID
    assign load_use_hazard = idex_mem_read &&
                             ((idex_rd_addr == ifid_rs_addr) ||
                              (idex_rd_addr == real_rt_addr));

    // Resolved target differs from what was fetched behind the branch
    assign branch_hazard = (predicted_idex_pc != target_exmem_pc);

    ////////////////////////////////////////////////////////////
    // Priority resolution where later rules win
    ////////////////////////////////////////////////////////////

    always_comb begin
        pc_src     = PC_PREDICT;
        stall      = '0;
        flush      = '0;
        cp0_req    = '0;
        bpu_update = '0;

        // Hold fetch and decode, bubble into EX
        if (load_use_hazard && !branch_hazard) begin
            stall.pc   = 1'b1;
            stall.ifid = 1'b1;
            flush.idex = 1'b1;
        end

        // Mispredict squashes everything younger than MEM
        if (branch_hazard) begin
            flush.ifid  = 1'b1;
            flush.idex  = 1'b1;
            flush.exmem = 1'b1;
            if (!cp0_intr) begin
                pc_src = PC_CORRECT;
            end
            bpu_update.en     = 1'b1;
            bpu_update.pc     = exmem_pc;
            bpu_update.target = target_exmem_pc;
        end

        if (id_jump && !branch_hazard) begin
            pc_src     = PC_JUMP;
            flush.ifid = 1'b1;
        end

        if (id_jr && !branch_hazard) begin
            pc_src     = PC_JR;
            flush.ifid = 1'b1;
        end

        // Syscall returns to the instruction after it
        if (exmem_syscall) begin
            pc_src           = PC_VECTOR;
            cp0_req.w_en     = 1'b1;
            cp0_req.exc_code = EXC_SYSCALL;
            cp0_req.epc      = predicted_idex_pc;
        end

        // Interrupt resumes at the path that should have run
        if (cp0_intr) begin
            pc_src           = PC_VECTOR;
            cp0_req.w_en     = 1'b1;
            cp0_req.exc_code = EXC_INT;
            if (branch_hazard) begin
                cp0_req.epc = target_exmem_pc;
            end else begin
                cp0_req.epc = predicted_idex_pc;
            end
        end

        if (exmem_eret && !branch_hazard) begin
            pc_src       = PC_EPC;
            cp0_req.eret = 1'b1;
        end

        // Busy memory freezes the whole front end
        if (mem_stall) begin
            stall.pc    = 1'b1;
            stall.ifid  = 1'b1;
            stall.idex  = 1'b1;
            stall.exmem = 1'b1;
        end
    end

endmodule

// ==== hw/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit #(
    parameter pipe_ctrl_pkg::addr_t RESET_PC   = 32'hBFC0_0000,
    parameter pipe_ctrl_pkg::addr_t EXC_VECTOR = 32'h8000_0180
) (
    input  logic                   clk,
    input  logic                   rst,
    input  pipe_ctrl_pkg::pc_src_e pc_src,
    input  logic                   stall_pc,
    input  pipe_ctrl_pkg::addr_t   jump_target,
    input  pipe_ctrl_pkg::addr_t   jr_target,
    input  pipe_ctrl_pkg::addr_t   epc,
    input  pipe_ctrl_pkg::addr_t   correct_target,
    input  pipe_ctrl_pkg::addr_t   predicted_pc,
    output pipe_ctrl_pkg::addr_t   pc
);

    import pipe_ctrl_pkg::*;

    addr_t pc_q;
    addr_t pc_next;

    ////////////////////////////////////////////////////////////
    // Next fetch address
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (pc_src)
            PC_JUMP: begin
                pc_next = jump_target;
            end
            PC_JR: begin
                pc_next = jr_target;
            end
            PC_VECTOR: begin
                pc_next = EXC_VECTOR;
            end
            PC_EPC: begin
                pc_next = epc;
            end
            PC_CORRECT: begin
                pc_next = correct_target;
            end
            default: begin
                // Normal flow follows the BTB
                pc_next = predicted_pc;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // PC register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (!stall_pc) begin
            pc_q <= pc_next;
        end
    end

    assign pc = pc_q;

endmodule

// ==== hw/pipe_ctrl_pkg.sv ====
package pipe_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // Basic widths
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  exc_code_t;

    // Cause codes written into CP0
    localparam exc_code_t EXC_INT     = 5'd0;
    localparam exc_code_t EXC_SYSCALL = 5'd8;

    // Next fetch address select
    typedef enum logic [3:0] {
        PC_JUMP    = 4'd0,
        PC_JR      = 4'd1,
        PC_VECTOR  = 4'd2,
        PC_EPC     = 4'd3,
        PC_CORRECT = 4'd4,
        PC_PREDICT = 4'd5
    } pc_src_e;

    ////////////////////////////////////////////////////////////
    // Control bundles
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic pc;
        logic ifid;
        logic idex;
        logic exmem;
    } stall_ctrl_t;

    typedef struct packed {
        logic ifid;
        logic idex;
        logic exmem;
    } flush_ctrl_t;

    // Exception entry or return request to CP0
    typedef struct packed {
        logic      w_en;
        exc_code_t exc_code;
        addr_t     epc;
        logic      eret;
    } cp0_req_t;

    // BTB retrain after a mispredict
    typedef struct packed {
        logic  en;
        addr_t pc;
        addr_t target;
    } bpu_update_t;

endpackage

// ==== hw/pipe_ctrl_top.sv ====
`timescale 1ns/1ps

module pipe_ctrl_top #(
    parameter pipe_ctrl_pkg::addr_t RESET_PC       = 32'hBFC0_0000,
    parameter pipe_ctrl_pkg::addr_t EXC_VECTOR     = 32'h8000_0180,
    parameter int                   BTB_INDEX_BITS = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    // Decode stage redirects
    input  logic                       id_jump,
    input  logic                       id_jr,
    input  pipe_ctrl_pkg::addr_t       id_jump_target,
    input  pipe_ctrl_pkg::addr_t       id_jr_target,
    // Load-use operands
    input  pipe_ctrl_pkg::reg_addr_t   ifid_rs_addr,
    input  pipe_ctrl_pkg::reg_addr_t   real_rt_addr,
    input  pipe_ctrl_pkg::reg_addr_t   idex_rd_addr,
    input  logic                       idex_mem_read,
    // Branch resolution
    input  pipe_ctrl_pkg::addr_t       predicted_idex_pc,
    input  pipe_ctrl_pkg::addr_t       target_exmem_pc,
    input  pipe_ctrl_pkg::addr_t       exmem_pc,
    // Exceptions and memory back-pressure
    input  logic                       exmem_syscall,
    input  logic                       exmem_eret,
    input  logic                       ext_intr,
    input  logic                       mem_stall,
    output pipe_ctrl_pkg::addr_t       pc,
    output pipe_ctrl_pkg::stall_ctrl_t stall,
    output pipe_ctrl_pkg::flush_ctrl_t flush,
    output pipe_ctrl_pkg::addr_t       epc,
    output pipe_ctrl_pkg::exc_code_t   cause
);

    import pipe_ctrl_pkg::*;

    pc_src_e     pc_src;
    cp0_req_t    cp0_req;
    bpu_update_t bpu_update;
    logic        cp0_intr;
    addr_t       predicted_pc;

    hazard_control i_hazard_control (
        .id_jr             (id_jr),
        .id_jump           (id_jump),
        .mem_stall         (mem_stall),
        .idex_mem_read     (idex_mem_read),
        .exmem_eret        (exmem_eret),
        .exmem_syscall     (exmem_syscall),
        .cp0_intr          (cp0_intr),
        .ifid_rs_addr      (ifid_rs_addr),
        .real_rt_addr      (real_rt_addr),
        .idex_rd_addr      (idex_rd_addr),
        .predicted_idex_pc (predicted_idex_pc),
        .target_exmem_pc   (target_exmem_pc),
        .exmem_pc          (exmem_pc),
        .pc_src            (pc_src),
        .stall             (stall),
        .flush             (flush),
        .cp0_req           (cp0_req),
        .bpu_update        (bpu_update)
    );

    pc_unit #(
        .RESET_PC   (RESET_PC),
        .EXC_VECTOR (EXC_VECTOR)
    ) i_pc_unit (
        .clk            (clk),
        .rst            (rst),
        .pc_src         (pc_src),
        .stall_pc       (stall.pc),
        .jump_target    (id_jump_target),
        .jr_target      (id_jr_target),
        .epc            (epc),
        .correct_target (target_exmem_pc),
        .predicted_pc   (predicted_pc),
        .pc             (pc)
    );

    branch_predictor #(
        .BTB_INDEX_BITS (BTB_INDEX_BITS)
    ) i_branch_predictor (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .update       (bpu_update),
        .predicted_pc (predicted_pc)
    );

    cp0_regs i_cp0_regs (
        .clk      (clk),
        .rst      (rst),
        .req      (cp0_req),
        .ext_intr (ext_intr),
        .cp0_intr (cp0_intr),
        .epc      (epc),
        .cause    (cause)
    );

endmodule

// ==== include/pipe_ctrl_tests.svh ====
////////////////////////////////////////////////////////////
// Directed tests that start and end at a falling edge
////////////////////////////////////////////////////////////

task automatic reset_and_fetch();
    addr_t exp_pc;
    exp_pc = RESET_PC;
    check_addr("pc", exp_pc, pc);
    // Empty BTB gives plain sequential fetch
    repeat (4) begin
        @(posedge clk);
        @(negedge clk);
        exp_pc = exp_pc + 32'd4;
        check_addr("pc", exp_pc, pc);
        check_stall("stall", stall_bits(0, 0, 0, 0), stall);
        check_flush("flush", flush_bits(0, 0, 0), flush);
    end
endtask

task automatic load_use_and_mem_stall(input addr_t start_pc);
    reg_addr_t rd;
    addr_t     exp_pc;
    rd     = reg_addr_t'($random(seed));
    exp_pc = start_pc;
    // First pass matches rs, second matches rt
    for (int i = 0; i < 2; i++) begin
        @(posedge clk);
        idex_mem_read <= 1'b1;
        idex_rd_addr  <= rd;
        ifid_rs_addr  <= (i == 0) ? rd : rd + 5'd1;
        real_rt_addr  <= (i == 0) ? rd + 5'd1 : rd;
        @(negedge clk);
        exp_pc = exp_pc + 32'd4;
        check_addr("pc", exp_pc, pc);
        check_stall("stall", stall_bits(1, 1, 0, 0), stall);
        check_flush("flush", flush_bits(0, 1, 0), flush);
        finish_cycle();
        check_addr("pc", exp_pc, pc);
    end
    @(posedge clk);
    mem_stall <= 1'b1;
    @(negedge clk);
    exp_pc = exp_pc + 32'd4;
    check_addr("pc", exp_pc, pc);
    check_stall("stall", stall_bits(1, 1, 1, 1), stall);
    check_flush("flush", flush_bits(0, 0, 0), flush);
    finish_cycle();
    check_addr("pc", exp_pc, pc);
endtask

task automatic mispredict_and_retrain();
    addr_t target;
    addr_t br_pc;
    target = rand_addr(32'h0040_0000);
    br_pc  = target + 32'd12;
    @(posedge clk);
    exmem_pc          <= br_pc;
    predicted_idex_pc <= br_pc + 32'd4;
    target_exmem_pc   <= target;
    @(negedge clk);
    check_flush("flush", flush_bits(1, 1, 1), flush);
    check_stall("stall", stall_bits(0, 0, 0, 0), stall);
    finish_cycle();
    check_addr("pc", target, pc);
    // Walking onto the trained branch jumps back to its target
    wait_for_pc(br_pc);
    @(posedge clk);
    @(negedge clk);
    check_addr("pc", target, pc);
endtask

task automatic jump_and_jr_redirects();
    addr_t jump_target;
    addr_t jr_target;
    addr_t fix_target;
    jump_target = rand_addr(32'h0010_0000);
    jr_target   = rand_addr(32'h0018_0000);
    fix_target  = rand_addr(32'h0020_0000);
    @(posedge clk);
    id_jump        <= 1'b1;
    id_jump_target <= jump_target;
    @(negedge clk);
    check_flush("flush", flush_bits(1, 0, 0), flush);
    finish_cycle();
    check_addr("pc", jump_target, pc);
    @(posedge clk);
    id_jr        <= 1'b1;
    id_jr_target <= jr_target;
    @(negedge clk);
    check_flush("flush", flush_bits(1, 0, 0), flush);
    finish_cycle();
    check_addr("pc", jr_target, pc);
    // Mispredict in the same cycle wins over both
    @(posedge clk);
    id_jump           <= 1'b1;
    id_jr             <= 1'b1;
    id_jump_target    <= jump_target;
    id_jr_target      <= jr_target;
    exmem_pc          <= 32'h0000_1000;
    predicted_idex_pc <= 32'h0000_1004;
    target_exmem_pc   <= fix_target;
    @(negedge clk);
    check_flush("flush", flush_bits(1, 1, 1), flush);
    finish_cycle();
    check_addr("pc", fix_target, pc);
endtask

task automatic exception_entry_and_return();
    addr_t ret_pc;
    addr_t good_pc;
    ret_pc  = rand_addr(32'h0030_0000);
    good_pc = rand_addr(32'h0050_0000);
    // Syscall saves the fetched pc even when the branch resolved elsewhere
    @(posedge clk);
    exmem_syscall     <= 1'b1;
    predicted_idex_pc <= ret_pc;
    target_exmem_pc   <= ret_pc + 32'd4;
    finish_cycle();
    check_addr("pc", EXC_VECTOR, pc);
    check_addr("epc", ret_pc, epc);
    check_code("cause", CODE_SYSCALL, cause);
    // Masked inside the handler
    @(posedge clk);
    ext_intr <= 1'b1;
    finish_cycle();
    check_addr("pc", EXC_VECTOR + 32'd8, pc);
    check_addr("epc", ret_pc, epc);
    check_code("cause", CODE_SYSCALL, cause);
    @(posedge clk);
    exmem_eret <= 1'b1;
    finish_cycle();
    check_addr("pc", ret_pc, pc);
    // Interrupt under a mispredict saves the resolved target
    @(posedge clk);
    ext_intr          <= 1'b1;
    exmem_pc          <= 32'h0000_2000;
    predicted_idex_pc <= 32'h0000_2004;
    target_exmem_pc   <= good_pc;
    @(negedge clk);
    check_flush("flush", flush_bits(1, 1, 1), flush);
    finish_cycle();
    check_addr("pc", EXC_VECTOR, pc);
    check_addr("epc", good_pc, epc);
    check_code("cause", CODE_INT, cause);
    @(posedge clk);
    exmem_eret <= 1'b1;
    finish_cycle();
    check_addr("pc", good_pc, pc);
    // Without a hazard the fall-through pc is saved
    @(posedge clk);
    ext_intr          <= 1'b1;
    predicted_idex_pc <= ret_pc;
    target_exmem_pc   <= ret_pc;
    finish_cycle();
    check_addr("pc", EXC_VECTOR, pc);
    check_addr("epc", ret_pc, epc);
    check_code("cause", CODE_INT, cause);
endtask

// ==== tb/pipe_ctrl_tb.sv ====
`timescale 1ns/1ps

module pipe_ctrl_tb;

    import pipe_ctrl_pkg::*;

    localparam addr_t     RESET_PC     = 32'hBFC0_0000;
    localparam addr_t     EXC_VECTOR   = 32'h8000_0180;
    localparam exc_code_t CODE_SYSCALL = 5'd8;
    localparam exc_code_t CODE_INT     = 5'd0;
    localparam int        WAIT_LIMIT   = 20;

    logic        clk;
    logic        rst;
    logic        id_jump;
    logic        id_jr;
    addr_t       id_jump_target;
    addr_t       id_jr_target;
    reg_addr_t   ifid_rs_addr;
    reg_addr_t   real_rt_addr;
    reg_addr_t   idex_rd_addr;
    logic        idex_mem_read;
    addr_t       predicted_idex_pc;
    addr_t       target_exmem_pc;
    addr_t       exmem_pc;
    logic        exmem_syscall;
    logic        exmem_eret;
    logic        ext_intr;
    logic        mem_stall;
    addr_t       pc;
    stall_ctrl_t stall;
    flush_ctrl_t flush;
    addr_t       epc;
    exc_code_t   cause;

    int     errors;
    integer seed;

    pipe_ctrl_top i_dut (
        .clk               (clk),
        .rst               (rst),
        .id_jump           (id_jump),
        .id_jr             (id_jr),
        .id_jump_target    (id_jump_target),
        .id_jr_target      (id_jr_target),
        .ifid_rs_addr      (ifid_rs_addr),
        .real_rt_addr      (real_rt_addr),
        .idex_rd_addr      (idex_rd_addr),
        .idex_mem_read     (idex_mem_read),
        .predicted_idex_pc (predicted_idex_pc),
        .target_exmem_pc   (target_exmem_pc),
        .exmem_pc          (exmem_pc),
        .exmem_syscall     (exmem_syscall),
        .exmem_eret        (exmem_eret),
        .ext_intr          (ext_intr),
        .mem_stall         (mem_stall),
        .pc                (pc),
        .stall             (stall),
        .flush             (flush),
        .epc               (epc),
        .cause             (cause)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_stall(input string name, input stall_ctrl_t exp,
                               input stall_ctrl_t act);
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_flush(input string name, input flush_ctrl_t exp,
                               input flush_ctrl_t act);
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_code(input string name, input exc_code_t exp, input exc_code_t act);
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    // Equal predicted and resolved targets keep the branch hazard off
    task automatic idle_inputs();
        id_jump           <= 1'b0;
        id_jr             <= 1'b0;
        id_jump_target    <= '0;
        id_jr_target      <= '0;
        ifid_rs_addr      <= '0;
        real_rt_addr      <= '0;
        idex_rd_addr      <= '0;
        idex_mem_read     <= 1'b0;
        predicted_idex_pc <= '0;
        target_exmem_pc   <= '0;
        exmem_pc          <= '0;
        exmem_syscall     <= 1'b0;
        exmem_eret        <= 1'b0;
        ext_intr          <= 1'b0;
        mem_stall         <= 1'b0;
    endtask

    // Let the driven cycle take effect and sample mid-cycle
    task automatic finish_cycle();
        @(posedge clk);
        idle_inputs();
        @(negedge clk);
    endtask

    task automatic wait_for_pc(input addr_t want);
        int count;
        count = 0;
        while (pc !== want && count < WAIT_LIMIT) begin
            @(posedge clk);
            @(negedge clk);
            count++;
        end
        if (pc !== want) begin
            errors++;
            $display("Timed out at %0t waiting for pc to reach %h", $time, want);
        end
    endtask

    function automatic stall_ctrl_t stall_bits(input logic s_pc, input logic s_ifid,
                                               input logic s_idex, input logic s_exmem);
        stall_ctrl_t s;
        s.pc    = s_pc;
        s.ifid  = s_ifid;
        s.idex  = s_idex;
        s.exmem = s_exmem;
        return s;
    endfunction

    function automatic flush_ctrl_t flush_bits(input logic f_ifid, input logic f_idex,
                                               input logic f_exmem);
        flush_ctrl_t f;
        f.ifid  = f_ifid;
        f.idex  = f_idex;
        f.exmem = f_exmem;
        return f;
    endfunction

    // Word aligned address inside a region picked by base
    function automatic addr_t rand_addr(input addr_t base);
        addr_t offset;
        offset = addr_t'($random(seed)) & 32'h0000_03FF;
        return base | (offset << 2);
    endfunction

    `include "pipe_ctrl_tests.svh"

    initial begin
        errors = 0;
        seed   = 85;
        rst    = 1'b1;
        idle_inputs();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        reset_and_fetch();
        // Four sequential fetches past the reset address
        load_use_and_mem_stall(RESET_PC + 32'd16);
        mispredict_and_retrain();
        jump_and_jr_redirects();
        exception_entry_and_return();

        $display("Finished with %0d error(s)", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
